// ==== include/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// instruction and data word width
`define CPU_WORD_W 16

// pc and ram address width
`define CPU_ADDR_W 8

// general purpose registers r0..r7
`define CPU_NREGS 8

// ram words, one per address
`define CPU_MEM_DEPTH 256

`endif

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

  // top three instruction bits
  typedef enum logic [2:0] {
    OP_LDR  = 3'b011,
    OP_STR  = 3'b100,
    OP_ALU  = 3'b101,
    OP_MOV  = 3'b110,
    OP_HALT = 3'b111
  } opcode_t;

  // same encoding as the op field of alu instructions
  typedef enum logic [1:0] {
    ALU_ADD  = 2'b00,
    ALU_SUB  = 2'b01,
    ALU_AND  = 2'b10,
    ALU_NOTB = 2'b11
  } alu_op_t;

  // shift applied to the b operand
  typedef enum logic [1:0] {
    SH_NONE = 2'b00,
    SH_LSL  = 2'b01,
    SH_LSR  = 2'b10,
    SH_ASR  = 2'b11
  } shift_t;

  // register write-back source
  typedef enum logic [1:0] {
    VSEL_MDATA = 2'b00,
    VSEL_IMM8  = 2'b01,
    VSEL_PC    = 2'b10,
    VSEL_C     = 2'b11
  } vsel_t;

  // which instruction field names the register
  typedef enum logic [1:0] {
    NSEL_RN = 2'b00,
    NSEL_RD = 2'b01,
    NSEL_RM = 2'b10
  } nsel_t;

  typedef struct packed {
    logic v;
    logic n;
    logic z;
  } status_t;

endpackage

// ==== src/datapath_ctrl_if.sv ====
interface datapath_ctrl_if;

  // register file addressing and write-back
  cpu_pkg::vsel_t vsel;
  cpu_pkg::nsel_t nsel;
  logic           write;

  // operand and result register enables
  logic loada;
  logic loadb;
  logic asel;
  logic bsel;
  logic loadc;
  logic loads;

  // fetch and memory control
  logic loadpc;
  logic clrpc;
  logic loadir;
  logic mwrite;
  logic msel;

  modport ctrl (
    output vsel, nsel, write, loada, loadb, asel, bsel, loadc, loads,
    output loadpc, clrpc, loadir, mwrite, msel
  );

  // nsel is read off this side by the decoder
  modport dp (
    input vsel, nsel, write, loada, loadb, asel, bsel, loadc, loads,
    input loadpc, clrpc, loadir, mwrite, msel
  );

endinterface

// ==== src/instr_fields_if.sv ====
`include "cpu_config.svh"

interface instr_fields_if;

  // register numbers, same field for read and write
  logic [$clog2(`CPU_NREGS)-1:0] readnum;
  logic [$clog2(`CPU_NREGS)-1:0] writenum;

  // operation fields
  cpu_pkg::shift_t  shift;
  cpu_pkg::alu_op_t alu_op;

  // sign-extended immediates
  logic [`CPU_WORD_W-1:0] sximm5;
  logic [`CPU_WORD_W-1:0] sximm8;

  modport dec (output readnum, writenum, shift, alu_op, sximm5, sximm8);

  modport dp (input readnum, writenum, shift, alu_op, sximm5, sximm8);

endinterface

// ==== src/regfile.sv ====
`include "cpu_config.svh"

module regfile (
  input  logic                          clk,
  input  logic                          write,
  input  logic [$clog2(`CPU_NREGS)-1:0] writenum,
  input  logic [$clog2(`CPU_NREGS)-1:0] readnum,
  input  logic [`CPU_WORD_W-1:0]        data_in,
  output logic [`CPU_WORD_W-1:0]        data_out
);

  // r0..r7
  logic [`CPU_WORD_W-1:0] regs [`CPU_NREGS];

  // single write port, registered
  always_ff @(posedge clk) begin
    if (write) begin
      regs[writenum] <= data_in;
    end
  end

  // read is combinational so a/b load the same cycle
  assign data_out = regs[readnum];

endmodule

// ==== src/alu.sv ====
`include "cpu_config.svh"

module alu (
  input  logic [`CPU_WORD_W-1:0] ain,
  input  logic [`CPU_WORD_W-1:0] bin,
  input  cpu_pkg::alu_op_t       alu_op,
  output logic [`CPU_WORD_W-1:0] result,
  output cpu_pkg::status_t       flags
);

  localparam int MSB = `CPU_WORD_W - 1;

  logic [`CPU_WORD_W-1:0] sum;
  logic [`CPU_WORD_W-1:0] diff;

  assign sum  = ain + bin;
  assign diff = ain - bin;

  always_comb begin
    // overflow only means something for add and sub
    flags.v = 1'b0;
    case (alu_op)
      cpu_pkg::ALU_ADD: begin
        result  = sum;
        // like signs in, different sign out
        flags.v = (ain[MSB] == bin[MSB]) && (sum[MSB] != ain[MSB]);
      end
      cpu_pkg::ALU_SUB: begin
        result  = diff;
        // unlike signs in, sign flips away from a
        flags.v = (ain[MSB] != bin[MSB]) && (diff[MSB] != ain[MSB]);
      end
      cpu_pkg::ALU_AND: result = ain & bin;
      default:          result = ~bin;
    endcase
    flags.n = result[MSB];
    flags.z = (result == '0);
  end

endmodule

// ==== src/ram.sv ====
`include "cpu_config.svh"

module ram (
  input  logic                   clk,
  input  logic [`CPU_ADDR_W-1:0] addr,
  input  logic                   wr,
  input  logic [`CPU_WORD_W-1:0] wdata,
  output logic [`CPU_WORD_W-1:0] rdata
);

  logic [`CPU_WORD_W-1:0] mem [`CPU_MEM_DEPTH];

  // one port, shared address for read and write
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[addr] <= wdata;
    end
    // registered read, old data on a write cycle
    rdata <= mem[addr];
  end

endmodule

// ==== src/instr_decoder.sv ====
`include "cpu_config.svh"

module instr_decoder (
  input  logic [`CPU_WORD_W-1:0] ir,
  instr_fields_if.dec            fields,
  input  cpu_pkg::nsel_t         nsel
);

  logic [2:0] rn;
  logic [2:0] rd;
  logic [2:0] rm;
  logic       is_mov;

  // fixed register fields
  assign rn = ir[10:8];
  assign rd = ir[7:5];
  assign rm = ir[2:0];

  assign is_mov = (cpu_pkg::opcode_t'(ir[15:13]) == cpu_pkg::OP_MOV);

  // controller picks the field per state
  always_comb begin
    case (nsel)
      cpu_pkg::NSEL_RN: fields.readnum = rn;
      cpu_pkg::NSEL_RD: fields.readnum = rd;
      default:          fields.readnum = rm;
    endcase
  end

  assign fields.writenum = fields.readnum;

  // shift sits in bits 4:3
  assign fields.shift = cpu_pkg::shift_t'(ir[4:3]);

  // mov register passes b through the adder with a zeroed a
  assign fields.alu_op = is_mov ? cpu_pkg::ALU_ADD : cpu_pkg::alu_op_t'(ir[12:11]);

  assign fields.sximm5 = {{(`CPU_WORD_W - 5){ir[4]}}, ir[4:0]};
  assign fields.sximm8 = {{(`CPU_WORD_W - 8){ir[7]}}, ir[7:0]};

endmodule

// ==== src/datapath.sv ====
`include "cpu_config.svh"

module datapath (
  input  logic                   clk,
  input  logic                   rst,
  datapath_ctrl_if.dp            ctrl,
  instr_fields_if.dp             fields,
  input  logic                   load,
  input  logic [`CPU_ADDR_W-1:0] load_addr,
  input  logic [`CPU_WORD_W-1:0] load_data,
  output logic [`CPU_WORD_W-1:0] ir,
  output logic [`CPU_WORD_W-1:0] datapath_out,
  output cpu_pkg::status_t       status
);

  logic [`CPU_WORD_W-1:0] data_in;
  logic [`CPU_WORD_W-1:0] data_out;
  logic [`CPU_WORD_W-1:0] a_q;
  logic [`CPU_WORD_W-1:0] b_q;
  logic [`CPU_WORD_W-1:0] c_q;
  logic [`CPU_WORD_W-1:0] b_shifted;
  logic [`CPU_WORD_W-1:0] ain;
  logic [`CPU_WORD_W-1:0] bin;
  logic [`CPU_WORD_W-1:0] alu_out;
  logic [`CPU_WORD_W-1:0] mdata;
  logic [`CPU_WORD_W-1:0] mem_wdata;
  logic [`CPU_ADDR_W-1:0] mem_addr;
  logic [`CPU_ADDR_W-1:0] pc;
  logic                   mem_wr;
  cpu_pkg::status_t       alu_flags;

  // write-back source
  always_comb begin
    case (ctrl.vsel)
      cpu_pkg::VSEL_MDATA: data_in = mdata;
      cpu_pkg::VSEL_IMM8:  data_in = fields.sximm8;
      cpu_pkg::VSEL_PC:    data_in = {{(`CPU_WORD_W - `CPU_ADDR_W){1'b0}}, pc};
      default:             data_in = c_q;
    endcase
  end

  regfile i_regfile (
    .clk      (clk),
    .write    (ctrl.write),
    .writenum (fields.writenum),
    .readnum  (fields.readnum),
    .data_in  (data_in),
    .data_out (data_out)
  );

  // operand registers
  always_ff @(posedge clk) begin
    if (ctrl.loada) begin
      a_q <= data_out;
    end
    if (ctrl.loadb) begin
      b_q <= data_out;
    end
  end

  // shifter on b
  always_comb begin
    case (fields.shift)
      cpu_pkg::SH_LSL: b_shifted = b_q << 1;
      cpu_pkg::SH_LSR: b_shifted = b_q >> 1;
      cpu_pkg::SH_ASR: b_shifted = $signed(b_q) >>> 1;
      default:         b_shifted = b_q;
    endcase
  end

  // zero a for mov and mvn, imm5 for address offsets
  assign ain = ctrl.asel ? '0 : a_q;
  assign bin = ctrl.bsel ? fields.sximm5 : b_shifted;

  alu i_alu (
    .ain    (ain),
    .bin    (bin),
    .alu_op (fields.alu_op),
    .result (alu_out),
    .flags  (alu_flags)
  );

  // result, status, pc and instruction registers
  always_ff @(posedge clk) begin
    if (rst) begin
      c_q    <= '0;
      status <= '0;
      pc     <= '0;
    end else begin
      if (ctrl.loadc) c_q <= alu_out;
      if (ctrl.loads) status <= alu_flags;
      if (ctrl.clrpc) pc <= '0;
      else if (ctrl.loadpc) pc <= pc + `CPU_ADDR_W'(1);
    end
    if (ctrl.loadir) begin
      ir <= mdata;
    end
  end

  // program load owns the port, the core is idle then
  assign mem_addr  = load ? load_addr : (ctrl.msel ? c_q[`CPU_ADDR_W-1:0] : pc);
  assign mem_wr    = load | ctrl.mwrite;
  assign mem_wdata = load ? load_data : b_q;

  ram i_ram (
    .clk   (clk),
    .addr  (mem_addr),
    .wr    (mem_wr),
    .wdata (mem_wdata),
    .rdata (mdata)
  );

  assign datapath_out = c_q;

endmodule

// ==== src/controller.sv ====
`include "cpu_config.svh"

module controller (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  input  logic [`CPU_WORD_W-1:0] ir,
  datapath_ctrl_if.ctrl          ctrl,
  output logic                   halted
);

  typedef enum logic [4:0] {
    S_IDLE, S_FETCH_ADDR, S_FETCH_LATCH, S_DECODE, S_MOVI_WB,
    S_UN_B, S_UN_C, S_BIN_A, S_BIN_B, S_BIN_C, S_RD_WB, S_CMP_S,
    S_MEM_A, S_MEM_C, S_LDR_ADDR, S_LDR_DATA, S_LDR_WB,
    S_STR_B, S_STR_ADDR, S_STR_WR, S_HALT
  } state_t;

  state_t            state;
  state_t            next;
  cpu_pkg::opcode_t  opcode;
  logic [1:0]        op;

  assign opcode = cpu_pkg::opcode_t'(ir[15:13]);
  assign op     = ir[12:11];

  always_ff @(posedge clk) begin
    if (rst) state <= S_IDLE;
    else     state <= next;
  end

  always_comb begin
    next = state;
    case (state)
      S_IDLE:        if (run) next = S_FETCH_ADDR;
      S_FETCH_ADDR:  next = S_FETCH_LATCH;
      S_FETCH_LATCH: next = S_DECODE;
      S_DECODE: begin
        case (opcode)
          // op 10 is mov immediate
          cpu_pkg::OP_MOV: next = (op == 2'b10) ? S_MOVI_WB : S_UN_B;
          // mvn has no a operand
          cpu_pkg::OP_ALU: next = (op == 2'b11) ? S_UN_B : S_BIN_A;
          cpu_pkg::OP_LDR, cpu_pkg::OP_STR: next = S_MEM_A;
          default:         next = S_HALT;
        endcase
      end
      S_UN_B:     next = S_UN_C;
      S_UN_C:     next = S_RD_WB;
      S_BIN_A:    next = S_BIN_B;
      // cmp only updates status
      S_BIN_B:    next = (op == 2'b01) ? S_CMP_S : S_BIN_C;
      S_BIN_C:    next = S_RD_WB;
      S_MEM_A:    next = S_MEM_C;
      S_MEM_C:    next = (opcode == cpu_pkg::OP_LDR) ? S_LDR_ADDR : S_STR_B;
      S_LDR_ADDR: next = S_LDR_DATA;
      S_LDR_DATA: next = S_LDR_WB;
      S_STR_B:    next = S_STR_ADDR;
      S_STR_ADDR: next = S_STR_WR;
      S_HALT:     next = S_HALT;
      // last execute state of every class
      default:    next = S_FETCH_ADDR;
    endcase
  end

  always_comb begin
    ctrl.vsel   = cpu_pkg::VSEL_C;
    ctrl.nsel   = cpu_pkg::NSEL_RD;
    ctrl.write  = 1'b0;
    ctrl.loada  = 1'b0;
    ctrl.loadb  = 1'b0;
    ctrl.asel   = 1'b0;
    ctrl.bsel   = 1'b0;
    ctrl.loadc  = 1'b0;
    ctrl.loads  = 1'b0;
    ctrl.loadpc = 1'b0;
    ctrl.clrpc  = 1'b0;
    ctrl.loadir = 1'b0;
    ctrl.mwrite = 1'b0;
    ctrl.msel   = 1'b0;
    case (state)
      // program starts at address 0
      S_IDLE:        ctrl.clrpc = run;
      S_FETCH_LATCH: begin ctrl.loadir = 1'b1; ctrl.loadpc = 1'b1; end
      S_MOVI_WB: begin
        ctrl.nsel  = cpu_pkg::NSEL_RN;
        ctrl.vsel  = cpu_pkg::VSEL_IMM8;
        ctrl.write = 1'b1;
      end
      S_UN_B, S_BIN_B: begin ctrl.nsel = cpu_pkg::NSEL_RM; ctrl.loadb = 1'b1; end
      S_UN_C:        begin ctrl.asel = 1'b1; ctrl.loadc = 1'b1; end
      S_BIN_A, S_MEM_A: begin ctrl.nsel = cpu_pkg::NSEL_RN; ctrl.loada = 1'b1; end
      S_BIN_C:       ctrl.loadc = 1'b1;
      S_RD_WB:       ctrl.write = 1'b1;
      S_CMP_S:       ctrl.loads = 1'b1;
      // address is rn plus offset
      S_MEM_C:       begin ctrl.bsel = 1'b1; ctrl.loadc = 1'b1; end
      S_LDR_ADDR, S_LDR_DATA, S_STR_ADDR: ctrl.msel = 1'b1;
      S_LDR_WB: begin
        ctrl.msel  = 1'b1;
        ctrl.vsel  = cpu_pkg::VSEL_MDATA;
        ctrl.write = 1'b1;
      end
      // rd is the store data
      S_STR_B:       ctrl.loadb = 1'b1;
      S_STR_WR:      begin ctrl.msel = 1'b1; ctrl.mwrite = 1'b1; end
      default:       ;
    endcase
  end

  assign halted = (state == S_HALT);

endmodule

// ==== src/cpu.sv ====
`include "cpu_config.svh"

module cpu (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  input  logic                   load,
  input  logic [`CPU_ADDR_W-1:0] load_addr,
  input  logic [`CPU_WORD_W-1:0] load_data,
  output logic                   halted,
  output logic [`CPU_WORD_W-1:0] datapath_out,
  output cpu_pkg::status_t       status
);

  logic [`CPU_WORD_W-1:0] ir;

  datapath_ctrl_if ctrl_bus ();
  instr_fields_if  fields_bus ();

  controller i_controller (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .ir     (ir),
    .ctrl   (ctrl_bus.ctrl),
    .halted (halted)
  );

  // register select follows the controller's nsel
  instr_decoder i_instr_decoder (
    .ir     (ir),
    .fields (fields_bus.dec),
    .nsel   (ctrl_bus.nsel)
  );

  datapath i_datapath (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl_bus.dp),
    .fields       (fields_bus.dp),
    .load         (load),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .ir           (ir),
    .datapath_out (datapath_out),
    .status       (status)
  );

endmodule

// ==== test/tb_cpu.sv ====
`include "cpu_config.svh"

module tb_cpu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FIXED  = 14;
  localparam int NUM_RANDOM = 4;
  localparam int NUM_TESTS  = NUM_FIXED + NUM_RANDOM;
  localparam int PROG_WORDS = 8;
  // eight words at up to eight cycles each, plus reset, load and hold time
  localparam int CYCLE_LIMIT = NUM_TESTS * (PROG_WORDS * 8 + 20);

  logic                   clk;
  logic                   rst;
  logic                   run;
  logic                   load;
  logic [`CPU_ADDR_W-1:0] load_addr;
  logic [`CPU_WORD_W-1:0] load_data;
  logic                   halted;
  logic [`CPU_WORD_W-1:0] datapath_out;
  cpu_pkg::status_t       status;

  // stimulus table, one row per program
  string                  test_name   [NUM_TESTS];
  logic [`CPU_WORD_W-1:0] test_prog   [NUM_TESTS][PROG_WORDS];
  logic [`CPU_WORD_W-1:0] test_out    [NUM_TESTS];
  logic [2:0]             test_status [NUM_TESTS];
  int                     num_entries = 0;

  logic [15:0] lfsr_state  = 16'd97;
  int unsigned cycle_count = 0;

  cpu i_cpu (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .load         (load),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .halted       (halted),
    .datapath_out (datapath_out),
    .status       (status)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // whole-run watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the CPU never halted within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken, msb first
  task automatic take_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[14:0], lfsr_state[15]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // instruction encoders, field layout of the isa
  function automatic logic [15:0] enc_movi(input logic [2:0] rn, input logic [7:0] imm8);
    return {cpu_pkg::OP_MOV, 2'b10, rn, imm8};
  endfunction

  function automatic logic [15:0] enc_movr(input logic [2:0] rd, input logic [2:0] rm,
                                           input cpu_pkg::shift_t sh);
    return {cpu_pkg::OP_MOV, 2'b00, 3'b000, rd, sh, rm};
  endfunction

  function automatic logic [15:0] enc_alu(input cpu_pkg::alu_op_t op, input logic [2:0] rn,
                                          input logic [2:0] rd, input logic [2:0] rm,
                                          input cpu_pkg::shift_t sh);
    return {cpu_pkg::OP_ALU, op, rn, rd, sh, rm};
  endfunction

  function automatic logic [15:0] enc_ldr(input logic [2:0] rd, input logic [2:0] rn,
                                          input logic [4:0] imm5);
    return {cpu_pkg::OP_LDR, 2'b00, rn, rd, imm5};
  endfunction

  function automatic logic [15:0] enc_str(input logic [2:0] rd, input logic [2:0] rn,
                                          input logic [4:0] imm5);
    return {cpu_pkg::OP_STR, 2'b00, rn, rd, imm5};
  endfunction

  function automatic logic [15:0] enc_halt();
    return {cpu_pkg::OP_HALT, 13'd0};
  endfunction

  // words packed first-in-msb, the rest of the slots become halt
  task automatic add_test(input string name, input int n, input logic [127:0] words,
                          input logic [15:0] exp_out, input logic [2:0] exp_status);
    test_name[num_entries] = name;
    for (int i = 0; i < PROG_WORDS; i++) begin
      if (i < n) test_prog[num_entries][i] = words[(n - 1 - i) * 16 +: 16];
      else       test_prog[num_entries][i] = enc_halt();
    end
    test_out[num_entries]    = exp_out;
    test_status[num_entries] = exp_status;
    num_entries++;
  endtask

  task automatic build_table();
    logic [15:0] a_bits;
    logic [15:0] b_bits;
    logic [15:0] sum;
    // shifts on mov register
    add_test("mov_none", 2, {enc_movi(3'd0, 8'h25),
             enc_movr(3'd1, 3'd0, cpu_pkg::SH_NONE)}, 16'h0025, 3'b000);
    add_test("mov_lsl", 2, {enc_movi(3'd0, 8'h41),
             enc_movr(3'd1, 3'd0, cpu_pkg::SH_LSL)}, 16'h0082, 3'b000);
    add_test("mov_lsr", 2, {enc_movi(3'd0, 8'h81),
             enc_movr(3'd1, 3'd0, cpu_pkg::SH_LSR)}, 16'h7fc0, 3'b000);
    add_test("mov_asr_neg", 2, {enc_movi(3'd0, 8'h80),
             enc_movr(3'd1, 3'd0, cpu_pkg::SH_ASR)}, 16'hffc0, 3'b000);
    // alu results, status untouched
    add_test("add", 3, {enc_movi(3'd0, 8'h05), enc_movi(3'd1, 8'hfd),
             enc_alu(cpu_pkg::ALU_ADD, 3'd0, 3'd2, 3'd1, cpu_pkg::SH_NONE)}, 16'h0002, 3'b000);
    add_test("add_shift", 3, {enc_movi(3'd0, 8'h0a), enc_movi(3'd1, 8'h03),
             enc_alu(cpu_pkg::ALU_ADD, 3'd0, 3'd2, 3'd1, cpu_pkg::SH_LSL)}, 16'h0010, 3'b000);
    add_test("and", 3, {enc_movi(3'd0, 8'h5c), enc_movi(3'd1, 8'h37),
             enc_alu(cpu_pkg::ALU_AND, 3'd0, 3'd2, 3'd1, cpu_pkg::SH_NONE)}, 16'h0014, 3'b000);
    add_test("mvn", 2, {enc_movi(3'd0, 8'h0f),
             enc_alu(cpu_pkg::ALU_NOTB, 3'd0, 3'd1, 3'd0, cpu_pkg::SH_NONE)}, 16'hfff0, 3'b000);
    // cmp keeps c from the instruction before, status is {v, n, z}
    add_test("cmp_equal", 4, {enc_movi(3'd0, 8'h09), enc_movi(3'd1, 8'h09),
             enc_movr(3'd2, 3'd0, cpu_pkg::SH_NONE),
             enc_alu(cpu_pkg::ALU_SUB, 3'd0, 3'd0, 3'd1, cpu_pkg::SH_NONE)}, 16'h0009, 3'b001);
    add_test("cmp_smaller", 4, {enc_movi(3'd0, 8'h02), enc_movi(3'd1, 8'h07),
             enc_alu(cpu_pkg::ALU_NOTB, 3'd0, 3'd3, 3'd1, cpu_pkg::SH_NONE),
             enc_alu(cpu_pkg::ALU_SUB, 3'd0, 3'd0, 3'd1, cpu_pkg::SH_NONE)}, 16'hfff8, 3'b010);
    // 0x7fc0 minus 0xff80 wraps past the largest positive word
    add_test("cmp_overflow", 4, {enc_movi(3'd0, 8'h81),
             enc_movr(3'd1, 3'd0, cpu_pkg::SH_LSR), enc_movi(3'd2, 8'h80),
             enc_alu(cpu_pkg::ALU_SUB, 3'd1, 3'd0, 3'd2, cpu_pkg::SH_NONE)}, 16'h7fc0, 3'b110);
    // data word at address 24, past the program
    add_test("str_ldr", 5, {enc_movi(3'd0, 8'h14), enc_movi(3'd1, 8'ha5),
             enc_str(3'd1, 3'd0, 5'd4), enc_ldr(3'd2, 3'd0, 5'd4),
             enc_movr(3'd3, 3'd2, cpu_pkg::SH_NONE)}, 16'hffa5, 3'b000);
    // 30 plus an offset of -6
    add_test("str_ldr_neg", 5, {enc_movi(3'd0, 8'h1e), enc_movi(3'd1, 8'h3c),
             enc_str(3'd1, 3'd0, 5'b11010), enc_ldr(3'd4, 3'd0, 5'b11010),
             enc_movr(3'd5, 3'd4, cpu_pkg::SH_LSL)}, 16'h0078, 3'b000);
    add_test("halt_only", 0, 128'd0, 16'h0000, 3'b000);
    // random imm8 pairs, sum of both sign-extended operands
    for (int i = 0; i < NUM_RANDOM; i++) begin
      take_bits(8, a_bits);
      take_bits(8, b_bits);
      sum = {{8{a_bits[7]}}, a_bits[7:0]} + {{8{b_bits[7]}}, b_bits[7:0]};
      add_test($sformatf("rand_add_%0d", i), 3,
               {enc_movi(3'd6, a_bits[7:0]), enc_movi(3'd7, b_bits[7:0]),
                enc_alu(cpu_pkg::ALU_ADD, 3'd6, 3'd5, 3'd7, cpu_pkg::SH_NONE)},
               sum, 3'b000);
    end
  endtask

  // ends on a falling edge with rst low
  task automatic reset_cpu();
    @(negedge clk);
    rst  = 1'b1;
    run  = 1'b0;
    load = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic load_program(input int t);
    for (int i = 0; i < PROG_WORDS; i++) begin
      load      = 1'b1;
      load_addr = `CPU_ADDR_W'(i);
      load_data = test_prog[t][i];
      @(negedge clk);
    end
    load = 1'b0;
  endtask

  // watchdog covers a core that never gets there
  task automatic wait_halted();
    while (halted !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic run_test(input int t);
    logic [15:0] held_out;
    reset_cpu();
    check({test_name[t], " halted after reset"}, 16'd0, {15'd0, halted});
    load_program(t);
    run = 1'b1;
    wait_halted();
    run = 1'b0;
    check({test_name[t], " datapath_out"}, test_out[t], datapath_out);
    check({test_name[t], " status"}, {13'd0, test_status[t]}, {13'd0, status});
    // halt is sticky and c stays put
    held_out = datapath_out;
    repeat (10) begin
      @(negedge clk);
      check({test_name[t], " halted held"}, 16'd1, {15'd0, halted});
      check({test_name[t], " datapath_out held"}, held_out, datapath_out);
    end
  endtask

  initial begin
    rst       = 1'b1;
    run       = 1'b0;
    load      = 1'b0;
    load_addr = '0;
    load_data = '0;
    build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
src/cpu_pkg.sv
src/datapath_ctrl_if.sv
src/instr_fields_if.sv
src/regfile.sv
src/alu.sv
src/ram.sv
src/instr_decoder.sv
src/datapath.sv
src/controller.sv
src/cpu.sv
test/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu16

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cpu_pkg.sv
      - src/datapath_ctrl_if.sv
      - src/instr_fields_if.sv
      - src/regfile.sv
      - src/alu.sv
      - src/ram.sv
      - src/instr_decoder.sv
      - src/datapath.sv
      - src/controller.sv
      - src/cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_cpu.sv
